/* common/rr_pkg.sv */
// Shared types and constants; refresh_div and fifo_depth must be at least 2, glyphs are active high

package rr_pkg;

    //------------------------------------------------------------------------
    // Tokens and queues

    localparam int w_count      = 3;                       // Count bits per source
    localparam int fifo_depth   = 4;
    localparam int w_fifo_ptr   = $clog2(fifo_depth);
    localparam int w_fifo_count = $clog2(fifo_depth + 1);

    // Bit 3 is the source tag, bits 2..0 the count
    typedef logic [w_count:0] token_t;

    //------------------------------------------------------------------------
    // Display

    localparam int refresh_div   = 4;                      // Cycles per digit
    localparam int w_refresh     = $clog2(refresh_div);
    localparam int n_digits      = 8;
    localparam int w_digit_index = $clog2(n_digits);

    typedef logic [7:0] seg_t;                             // abcdefgh

    localparam seg_t sign_ready_a   = 8'b1000_0000;        // Segment a
    localparam seg_t sign_ready_b   = 8'b0000_0010;        // Segment g
    localparam seg_t sign_ready_out = 8'b0001_0000;        // Segment d
    localparam seg_t sign_nothing   = 8'b0000_0000;

    localparam seg_t hex_glyphs [0:15] = '{
        8'b1111_1100, 8'b0110_0000, 8'b1101_1010, 8'b1111_0010,
        8'b0110_0110, 8'b1011_0110, 8'b1011_1110, 8'b1110_0000,
        8'b1111_1110, 8'b1111_0110, 8'b1110_1110, 8'b0011_1110,
        8'b1001_1100, 8'b0111_1010, 8'b1001_1110, 8'b1000_1110
    };

endpackage

/* logic/token_source.sv */
// Counter wraps from 7 to 0 with no overflow flag; the token only changes after an accepted push

module token_source
(
    input  logic           clk,
    input  logic           arst_n,
    input  logic           advance,   // Push accepted this cycle
    input  logic           tag,       // Source identity, tied off by the parent
    output rr_pkg::token_t token
);

    import rr_pkg::*;

    logic [w_count - 1:0] count;

    always_ff @ (posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            count <= '0;
        else if (advance)
            count <= count + 1'b1;  // Natural wrap
    end

    // Tag on top, count below
    assign token = { tag, count };

endmodule

/* fifo/flip_flop_fifo.sv */
// Register queue of fifo_depth entries; the head is visible combinationally and is not reset

module flip_flop_fifo
# (
    parameter type payload_t = rr_pkg::token_t
)
(
    input  logic     clk,
    input  logic     arst_n,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    import rr_pkg::*;

    payload_t                  mem [0:fifo_depth - 1];
    logic [w_fifo_ptr   - 1:0] wr_ptr;
    logic [w_fifo_ptr   - 1:0] rd_ptr;
    logic [w_fifo_count - 1:0] count;

    logic push;
    logic pop;

    //------------------------------------------------------------------------

    assign in_ready  = count != w_fifo_count'(fifo_depth);  // Not full
    assign out_valid = count != '0;                         // Not empty
    assign out_data  = mem[rd_ptr];

    assign push = in_valid  & in_ready;
    assign pop  = out_valid & out_ready;

    //------------------------------------------------------------------------
    // Storage, no reset needed

    always_ff @ (posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

    //------------------------------------------------------------------------
    // Pointers and occupancy

    always_ff @ (posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == w_fifo_ptr'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;

            if (pop)
                rd_ptr <= (rd_ptr == w_fifo_ptr'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;

            case ({ push, pop })
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;            // Both or neither
            endcase
        end
    end

endmodule

/* arbiter/round_robin_arbiter_2.sv */
// Two-way arbiter; request[0] is source A, and a pending grant is held until its transfer

module round_robin_arbiter_2
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic [1:0] request,
    input  logic       transfer,  // Granted head was taken this cycle
    output logic [1:0] grant
);

    logic favor_b;   // Round-robin pointer
    logic held;      // Last grant not taken yet
    logic held_b;    // Which source was holding

    //------------------------------------------------------------------------
    // A grant that has not completed keeps the output stable

    always_comb
    begin
        if (held)
            grant = held_b ? 2'b10 : 2'b01;
        else if (request == 2'b11)
            grant = favor_b ? 2'b10 : 2'b01;
        else
            grant = request;    // Lone requester wins
    end

    //------------------------------------------------------------------------

    always_ff @ (posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            favor_b <= 1'b0;    // A first
            held    <= 1'b0;
            held_b  <= 1'b0;
        end
        else
        begin
            if (transfer)
                favor_b <= grant[0];  // Point to the other source

            held   <= (|grant) & ~transfer;
            held_b <= grant[1];
        end
    end

endmodule

/* arbiter/arbitrated_fifo_pair.sv */
// Two queues share one output; the winning head is popped only when out_ready is high

module arbitrated_fifo_pair
(
    input  logic           clk,
    input  logic           arst_n,

    input  logic           a_valid,
    output logic           a_ready,
    input  rr_pkg::token_t a_data,

    input  logic           b_valid,
    output logic           b_ready,
    input  rr_pkg::token_t b_data,

    output logic           out_valid,
    input  logic           out_ready,
    output rr_pkg::token_t out_data
);

    import rr_pkg::*;

    logic   a_head_valid;
    logic   a_pop_ready;
    token_t a_head_data;

    logic   b_head_valid;
    logic   b_pop_ready;
    token_t b_head_data;

    logic [1:0] grant;
    logic       transfer;

    //------------------------------------------------------------------------

    flip_flop_fifo # (.payload_t (token_t)) i_a_fifo
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (a_valid),
        .in_ready  (a_ready),
        .in_data   (a_data),
        .out_valid (a_head_valid),
        .out_ready (a_pop_ready),
        .out_data  (a_head_data)
    );

    flip_flop_fifo # (.payload_t (token_t)) i_b_fifo
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (b_valid),
        .in_ready  (b_ready),
        .in_data   (b_data),
        .out_valid (b_head_valid),
        .out_ready (b_pop_ready),
        .out_data  (b_head_data)
    );

    //------------------------------------------------------------------------

    round_robin_arbiter_2 i_arbiter
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .request  ({ b_head_valid, a_head_valid }),
        .transfer (transfer),
        .grant    (grant)
    );

    // Grant only goes to a valid head
    assign out_valid = |grant;
    assign out_data  = grant[1] ? b_head_data : a_head_data;
    assign transfer  = out_valid & out_ready;

    assign a_pop_ready = out_ready & grant[0];
    assign b_pop_ready = out_ready & grant[1];

endmodule

/* logic/seven_segment_display.sv */
// Eight-digit multiplexed driver; segments and digit select are active high, one digit at a time

module seven_segment_display
(
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic [4 * rr_pkg::n_digits - 1:0] number,  // Digit 0 in the low nibble
    input  logic [    rr_pkg::n_digits - 1:0] dots,
    output rr_pkg::seg_t                      abcdefgh,
    output logic [    rr_pkg::n_digits - 1:0] digit
);

    import rr_pkg::*;

    logic [w_refresh     - 1:0] refresh_cnt;
    logic [w_digit_index - 1:0] index;
    logic                       refresh_tick;
    logic [3:0]                 nibble;

    //------------------------------------------------------------------------
    // Refresh timing

    assign refresh_tick = refresh_cnt == w_refresh'(refresh_div - 1);

    always_ff @ (posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            refresh_cnt <= '0;
        else if (refresh_tick)
            refresh_cnt <= '0;
        else
            refresh_cnt <= refresh_cnt + 1'b1;
    end

    // Digit 0 up to the last, then back
    always_ff @ (posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            index <= '0;
        else if (refresh_tick)
        begin
            if (index == w_digit_index'(n_digits - 1))
                index <= '0;
            else
                index <= index + 1'b1;
        end
    end

    //------------------------------------------------------------------------
    // Digit select and segment decode

    always_comb
    begin
        digit        = '0;
        digit[index] = 1'b1;
    end

    assign nibble = number[4 * index +: 4];

    // Dot lands on segment h
    assign abcdefgh = hex_glyphs[nibble] | seg_t'(dots[index]);

endmodule

/* logic/board_top.sv */
// Fixed three-key mapping, all on one clock; sw is kept for the board pinout and has no function

module board_top
(
    input  logic         clk,
    input  logic         arst_n,

    input  logic [2:0]   key,
    input  logic [7:0]   sw,
    output logic [7:0]   led,

    output rr_pkg::seg_t abcdefgh,
    output logic [7:0]   digit
);

    import rr_pkg::*;

    logic   a_valid;
    logic   a_ready;
    token_t a_data;

    logic   b_valid;
    logic   b_ready;
    token_t b_data;

    logic   out_valid;
    logic   out_ready;
    token_t out_data;

    logic   out_strobe;
    seg_t   abcdefgh_pre;

    //------------------------------------------------------------------------
    // Keys to requests

    assign a_valid   =   key[2];
    assign b_valid   =   key[1];
    assign out_ready = ~ key[0];  // Released key means ready

    assign out_strobe = out_valid & out_ready;

    //------------------------------------------------------------------------
    // Sources, A counts 0..7, B counts 8..f

    token_source i_a_source
    (
        .clk     (clk),
        .arst_n  (arst_n),
        .advance (a_valid & a_ready),
        .tag     (1'b0),
        .token   (a_data)
    );

    token_source i_b_source
    (
        .clk     (clk),
        .arst_n  (arst_n),
        .advance (b_valid & b_ready),
        .tag     (1'b1),
        .token   (b_data)
    );

    arbitrated_fifo_pair i_pair (.*);

    //------------------------------------------------------------------------
    // Display and status

    seven_segment_display i_display
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .number   ({ a_data, b_data, 20'h0, out_data }),
        .dots     ('0),
        .abcdefgh (abcdefgh_pre),
        .digit    (digit)
    );

    always_comb
    begin
        case (digit)
        8'b0000_0001: abcdefgh = out_valid ? abcdefgh_pre : sign_nothing;

        8'b0000_0010:                           // Status digit
        begin
            abcdefgh = sign_nothing;

            if (a_ready)
                abcdefgh |= sign_ready_a;
            if (b_ready)
                abcdefgh |= sign_ready_b;
            if (out_ready)
                abcdefgh |= sign_ready_out;
        end

        default: abcdefgh = abcdefgh_pre;
        endcase
    end

    assign led = { out_strobe, b_ready, a_ready, out_valid, out_data };

endmodule

/* test/rr_assert.sv */
// Bound into the arbitrated pair; its occupancy model assumes both queues are empty after reset

module rr_assert
(
    input logic           clk,
    input logic           arst_n,
    input logic           a_valid,
    input logic           a_ready,
    input logic           b_valid,
    input logic           b_ready,
    input logic           out_valid,
    input logic           out_ready,
    input rr_pkg::token_t out_data,
    input logic [1:0]     grant
);

    import rr_pkg::*;

    logic [w_fifo_count - 1:0] a_fill;
    logic [w_fifo_count - 1:0] b_fill;
    logic                      a_push;
    logic                      b_push;
    logic                      a_pop;
    logic                      b_pop;
    int                        fail_count = 0;

    assign a_push = a_valid & a_ready;
    assign b_push = b_valid & b_ready;
    assign a_pop  = out_valid & out_ready & grant[0];
    assign b_pop  = out_valid & out_ready & grant[1];

    // Occupancy seen from the ports
    always_ff @ (posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            a_fill <= '0;
            b_fill <= '0;
        end
        else
        begin
            a_fill <= a_fill + w_fifo_count'(a_push) - w_fifo_count'(a_pop);
            b_fill <= b_fill + w_fifo_count'(b_push) - w_fifo_count'(b_pop);
        end
    end

    //------------------------------------------------------------------------

    assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> $stable(out_data))
    else
    begin
        $error("out_data changed while the output was stalled");
        fail_count++;
    end

    // One-hot grant, only to a queue holding data, and never idle while one does
    assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(grant)
        && (!grant[0] || a_fill != '0)
        && (!grant[1] || b_fill != '0)
        && ((|grant) || (a_fill == '0 && b_fill == '0)))
    else
    begin
        $error("grant is not one-hot, points at an empty queue or is missing");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        !(a_push && a_fill == w_fifo_count'(fifo_depth))
        && !(b_push && b_fill == w_fifo_count'(fifo_depth)))
    else
    begin
        $error("push accepted into a full queue");
        fail_count++;
    end

endmodule

/* test/tb_board_top.sv */
// Reads test/rr_golden.txt relative to the project root; out_data is compared only while out_valid

module tb_board_top;

    import rr_pkg::*;

    localparam int max_lines = 64;

    logic         clk;
    logic         arst_n;
    logic [2:0]   key;
    logic [7:0]   sw;
    logic [7:0]   led;
    seg_t         abcdefgh;
    logic [7:0]   digit;

    logic [11:0]  golden [0:max_lines - 1];   // Key nibble, then LED byte
    int           n_lines;
    int           timeout_limit;
    int           cycles;
    int           led_errors;
    int           seg_errors;
    int           other_errors;
    int           assert_errors;

    board_top i_board_top
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .key      (key),
        .sw       (sw),
        .led      (led),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    bind arbitrated_fifo_pair rr_assert i_rr_assert
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .a_valid   (a_valid),
        .a_ready   (a_ready),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .grant     (grant)
    );

    //------------------------------------------------------------------------
    // Compare tasks and the display model

    task automatic check_led(input string name, input logic [7:0] actual,
                             input logic [7:0] expected);
        if (actual !== expected)
        begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
            led_errors++;
        end
    endtask

    task automatic check_seg(input string name, input seg_t actual, input seg_t expected);
        if (actual !== expected)
        begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, name, actual, expected);
            seg_errors++;
        end
    endtask

    function automatic int digit_index(input logic [7:0] onehot);
        int idx;
        idx = -1;
        for (int d = 0; d < n_digits; d++)
            if (onehot[d])
                idx = d;
        return idx;
    endfunction

    // Digit 7 and 6 are the sources, 1 is status, 0 the output token
    function automatic seg_t expected_glyph(input int idx, input token_t a_val,
                                            input token_t b_val, input logic [7:0] exp_led,
                                            input logic [2:0] keys);
        seg_t glyph;
        case (idx)
        7:       glyph = hex_glyphs[a_val];
        6:       glyph = hex_glyphs[b_val];
        1:
        begin
            glyph = sign_nothing;
            if (exp_led[5])
                glyph |= sign_ready_a;
            if (exp_led[6])
                glyph |= sign_ready_b;
            if (!keys[0])
                glyph |= sign_ready_out;    // Output ready while key released
        end
        0:       glyph = exp_led[4] ? hex_glyphs[exp_led[3:0]] : sign_nothing;
        default: glyph = hex_glyphs[0];     // Unused zero nibbles
        endcase
        return glyph;
    endfunction

    //------------------------------------------------------------------------

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial
    begin
        cycles = 0;
        while (cycles <= timeout_limit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the golden sequence did not finish", cycles);
        $display("*** FAILED ***");
        $finish;
    end

    initial
    begin
        logic [7:0]           exp_led;
        logic [7:0]           led_seen;
        logic [w_count - 1:0] a_count;
        logic [w_count - 1:0] b_count;
        logic [7:0]           prev_digit;
        int                   idx;
        int                   dwell;

        key           = '0;
        sw            = '0;
        arst_n        = 1'b0;
        led_errors    = 0;
        seg_errors    = 0;
        other_errors  = 0;
        a_count       = '0;
        b_count       = '0;
        prev_digit    = 8'h01;              // Digit 0 after reset
        dwell         = 0;

        for (int i = 0; i < max_lines; i++)
            golden[i] = 12'hfff;            // Marks lines the file leaves empty
        $readmemh("test/rr_golden.txt", golden);
        n_lines = 0;
        while (n_lines < max_lines && golden[n_lines] != 12'hfff)
            n_lines++;
        timeout_limit = n_lines + 50;

        if (n_lines == 0)
        begin
            $display("No stimulus lines were read from the golden file");
            other_errors++;
        end

        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        for (int i = 0; i < n_lines; i++)
        begin
            @(posedge clk);
            key <= golden[i][10:8];
            @(negedge clk);

            exp_led  = golden[i][7:0];
            led_seen = exp_led[4] ? led : { led[7:4], 4'h0 };  // Stale head when empty
            check_led("led", led_seen, exp_led);

            dwell++;                        // Cycles spent on the current digit
            if (digit !== prev_digit)
            begin
                if (dwell != refresh_div)
                begin
                    $display("Digit select advanced after %0d cycles instead of %0d at %0t",
                             dwell, refresh_div, $time);
                    other_errors++;
                end
                if (digit !== { prev_digit[6:0], prev_digit[7] })
                begin
                    $display("Digit select jumped from %b to %b at %0t",
                             prev_digit, digit, $time);
                    other_errors++;
                end
                idx = digit_index(digit);
                if (idx >= 0)
                    check_seg("abcdefgh", abcdefgh,
                              expected_glyph(idx, { 1'b0, a_count }, { 1'b1, b_count },
                                             exp_led, key));
                prev_digit = digit;
                dwell      = 0;
            end
            else if (dwell == refresh_div)
            begin
                $display("Digit select stayed on %b for more than %0d cycles at %0t",
                         digit, refresh_div, $time);
                other_errors++;
            end

            // Sources step on accepted pushes at the coming edge
            if (key[2] && exp_led[5])
                a_count++;
            if (key[1] && exp_led[6])
                b_count++;
        end

        @(negedge clk);
        assert_errors = i_board_top.i_pair.i_rr_assert.fail_count;
        $display("Errors: led %0d, display %0d, other %0d, assertion %0d",
                 led_errors, seg_errors, other_errors, assert_errors);
        if (led_errors + seg_errors + other_errors + assert_errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* test/rr_golden.txt */
// One line per cycle: first hex digit is key[2:0], last two are the expected led byte
// led = { strobe, b_ready, a_ready, out_valid, out_data }, out_data is 0 while not valid
060 // idle after reset
660 // both sources push, output ready
6f0
6f8
6f1
6f9
6f2
0ba // pushes stop, queues drain
0f3
0fb
0f4
0fc
0f5
0fd
260 // only B pushes while pointer favors A
2fe
2ff
2f8
2f9
0fa
760 // output held back, queues fill
776
776
776
716
716
716
096 // output released
0bb
0f7
0fc
0f0
0fd
0f1
0fe
060
060

/* sources.f */
common/rr_pkg.sv
logic/token_source.sv
fifo/flip_flop_fifo.sv
arbiter/round_robin_arbiter_2.sv
arbiter/arbitrated_fifo_pair.sv
logic/seven_segment_display.sv
logic/board_top.sv
test/rr_assert.sv
test/tb_board_top.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_board_top -f sources.f -o tb_board_top

output=$(./obj_dir/tb_board_top +verilator+error+limit+100)
echo "$output"

if grep -qF '*** PASSED ***' <<< "$output"
then
    exit 0
fi
exit 1
